//--- cpu_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Global sizes for the execute core
// Changing WORD_W breaks the fixed MIPS field slicing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and instruction width
`define WORD_W 32

// Architectural registers, r0 hardwired to zero
`define REG_COUNT 32

`define LINK_REG 31 // JAL return address lands here

`endif

//--- cpu_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the execute core
// Opcode and funct values follow classic MIPS-I
// LL and SC are listed but decode as no-ops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_defines.svh"

package cpu_types_pkg;

        typedef logic [`WORD_W-1:0] word_t;
        typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

        // Primary opcode field, instr[31:26]
        typedef enum logic [5:0] {
                RTYPE = 6'b000000,
                J     = 6'b000010,
                JAL   = 6'b000011,
                BEQ   = 6'b000100,
                BNE   = 6'b000101,
                ADDI  = 6'b001000,
                ADDIU = 6'b001001,
                SLTI  = 6'b001010,
                SLTIU = 6'b001011,
                ANDI  = 6'b001100,
                ORI   = 6'b001101,
                LUI   = 6'b001111,
                LW    = 6'b100011,
                SW    = 6'b101011,
                LL    = 6'b110000,
                SC    = 6'b111000,
                XORI  = 6'b001110
        } opcode_t;

        // R-type function field, instr[5:0]
        typedef enum logic [5:0] {
                SLL  = 6'b000000,
                SRL  = 6'b000010,
                JR   = 6'b001000,
                ADD  = 6'b100000,
                ADDU = 6'b100001,
                SUB  = 6'b100010,
                SUBU = 6'b100011,
                AND  = 6'b100100,
                OR   = 6'b100101,
                XOR  = 6'b100110,
                NOR  = 6'b100111,
                SLT  = 6'b101010,
                SLTU = 6'b101011
        } funct_t;

        typedef enum logic [3:0] {
                ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL
        } aluOp_t;

        typedef struct packed {
                logic   regDst;   // Write rd instead of rt
                logic   regWrite;
                logic   aluSrc;   // Operand B from immediate
                logic   memToReg;
                logic   dREN;
                logic   dWEN;
                logic   branch;
                logic   bne;
                logic   jmp;
                logic   jl;       // Link into r31
                logic   jmpReg;
                logic   shiftSel; // Operand A from shamt
                logic   zeroExt;
                logic   lui;
                aluOp_t aluOp;
        } ctrlWord_t;

        typedef struct packed {
                word_t rsVal;
                word_t rtVal;
        } operands_t;

        typedef struct packed {
                word_t nextPc;
                word_t aluResult;
                word_t dAddr;
                word_t storeData;
                logic  dREN;
                logic  dWEN;
        } execResult_t;

        typedef struct packed {
                logic    wen;
                regIdx_t waddr;
                word_t   wdata;
        } wbReq_t;

endpackage

//--- controlDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational decode
// Unknown opcodes and functs give a harmless no-op
// LL and SC are not implemented
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module controlDecoder (
        input  cpu_types_pkg::word_t     instr,
        output cpu_types_pkg::ctrlWord_t ctrl
);
        import cpu_types_pkg::*;

        opcode_t opcode;
        funct_t  funct;

        assign opcode = opcode_t'(instr[31:26]);
        assign funct  = funct_t'(instr[5:0]);

        always_comb begin
                ctrl       = '0;
                ctrl.aluOp = ALU_ADD;
                if (opcode == RTYPE) begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        case (funct)
                                SLL: begin
                                        ctrl.aluOp    = ALU_SLL;
                                        ctrl.shiftSel = 1'b1;
                                end
                                SRL: begin
                                        ctrl.aluOp    = ALU_SRL;
                                        ctrl.shiftSel = 1'b1;
                                end
                                JR: begin
                                        ctrl.regWrite = 1'b0; // Only redirects the PC
                                        ctrl.jmpReg   = 1'b1;
                                end
                                ADD, ADDU: ctrl.aluOp = ALU_ADD; // No overflow trap
                                SUB, SUBU: ctrl.aluOp = ALU_SUB;
                                AND:       ctrl.aluOp = ALU_AND;
                                OR:        ctrl.aluOp = ALU_OR;
                                XOR:       ctrl.aluOp = ALU_XOR;
                                NOR:       ctrl.aluOp = ALU_NOR;
                                SLT:       ctrl.aluOp = ALU_SLT;
                                SLTU:      ctrl.aluOp = ALU_SLTU;
                                default:   ctrl.regWrite = 1'b0;
                        endcase
                end else begin
                        // I and J type, immediate on operand B by default
                        ctrl.aluSrc = 1'b1;
                        case (opcode)
                                ADDI, ADDIU: ctrl.regWrite = 1'b1;
                                ANDI: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.aluOp    = ALU_AND;
                                        ctrl.zeroExt  = 1'b1;
                                end
                                ORI: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.aluOp    = ALU_OR;
                                        ctrl.zeroExt  = 1'b1;
                                end
                                XORI: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.aluOp    = ALU_XOR;
                                        ctrl.zeroExt  = 1'b1;
                                end
                                SLTI: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.aluOp    = ALU_SLT;
                                end
                                SLTIU: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.aluOp    = ALU_SLTU;
                                end
                                LUI: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.lui      = 1'b1;
                                end
                                LW: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.memToReg = 1'b1;
                                        ctrl.dREN     = 1'b1;
                                end
                                SW: ctrl.dWEN = 1'b1;
                                BEQ: begin
                                        ctrl.aluSrc = 1'b0; // Compare rs with rt
                                        ctrl.branch = 1'b1;
                                        ctrl.aluOp  = ALU_SUB;
                                end
                                BNE: begin
                                        ctrl.aluSrc = 1'b0;
                                        ctrl.branch = 1'b1;
                                        ctrl.bne    = 1'b1;
                                        ctrl.aluOp  = ALU_SUB;
                                end
                                J: ctrl.jmp = 1'b1;
                                JAL: begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.jmp      = 1'b1;
                                        ctrl.jl       = 1'b1;
                                end
                                default: ctrl.aluSrc = 1'b0; // LL, SC, unknown
                        endcase
                end
        end

        // A single instruction never both loads and stores
        always_comb begin
                memExclusive: assert final (!(ctrl.dREN && ctrl.dWEN))
                        else $error("decoder set dREN and dWEN for %h", instr);
        end

endmodule

//--- regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two async read ports, one write port
// Writes land on the rising edge
// No write-to-read bypass in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "cpu_defines.svh"

module regFile (
        input  logic                     clk,
        input  logic                     arstN,
        input  cpu_types_pkg::regIdx_t   rsIdx,
        input  cpu_types_pkg::regIdx_t   rtIdx,
        input  cpu_types_pkg::wbReq_t    wb,
        output cpu_types_pkg::operands_t ops
);
        import cpu_types_pkg::*;

        word_t regs [`REG_COUNT];

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wb.wen && wb.waddr != '0) begin // r0 never written
                        regs[wb.waddr] <= wb.wdata;
                end
        end

        always_comb begin
                ops.rsVal = (rsIdx == '0) ? '0 : regs[rsIdx];
                ops.rtVal = (rtIdx == '0) ? '0 : regs[rtIdx];
        end

        // A write request needs a known enable and a known target
        wbKnown: assert property (@(posedge clk) disable iff (!arstN)
                !$isunknown(wb.wen) && (!wb.wen || !$isunknown(wb.waddr)))
                else $error("write-back request with unknown enable or address");

endmodule

//--- aluUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage, all combinational
// ADD and SUB never trap on overflow
// Strobes and write enable follow instrValid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "cpu_defines.svh"

module aluUnit (
        input  logic                       instrValid,
        input  cpu_types_pkg::word_t       pc,
        input  cpu_types_pkg::word_t       instr,
        input  cpu_types_pkg::word_t       loadData,
        input  cpu_types_pkg::ctrlWord_t   ctrl,
        input  cpu_types_pkg::operands_t   ops,
        output cpu_types_pkg::execResult_t result,
        output cpu_types_pkg::wbReq_t      wb
);
        import cpu_types_pkg::*;

        word_t   immSext;
        word_t   immExt;
        word_t   opA;
        word_t   opB;
        word_t   aluOut;
        word_t   pcPlus4;
        word_t   branchTarget;
        logic    taken;
        regIdx_t rtIdx;
        regIdx_t rdIdx;

        assign rtIdx   = instr[20:16];
        assign rdIdx   = instr[15:11];
        assign immSext = {{(`WORD_W-16){instr[15]}}, instr[15:0]};
        assign immExt  = ctrl.zeroExt ? {{(`WORD_W-16){1'b0}}, instr[15:0]} : immSext;

        // Shifts take shamt on A and rt on B
        assign opA = ctrl.shiftSel ? {{(`WORD_W-5){1'b0}}, instr[10:6]} : ops.rsVal;
        assign opB = ctrl.aluSrc ? immExt : ops.rtVal;

        always_comb begin
                case (ctrl.aluOp)
                        ALU_ADD:  aluOut = opA + opB;
                        ALU_SUB:  aluOut = opA - opB;
                        ALU_AND:  aluOut = opA & opB;
                        ALU_OR:   aluOut = opA | opB;
                        ALU_XOR:  aluOut = opA ^ opB;
                        ALU_NOR:  aluOut = ~(opA | opB);
                        ALU_SLT:  aluOut = word_t'($signed(opA) < $signed(opB));
                        ALU_SLTU: aluOut = word_t'(opA < opB);
                        ALU_SLL:  aluOut = opB << opA[4:0];
                        ALU_SRL:  aluOut = opB >> opA[4:0];
                        default:  aluOut = '0;
                endcase
        end

        assign pcPlus4      = pc + word_t'(4);
        assign branchTarget = pcPlus4 + {immSext[`WORD_W-3:0], 2'b00};
        assign taken = ctrl.branch && ((ops.rsVal == ops.rtVal) != ctrl.bne);

        always_comb begin
                if (ctrl.jmpReg)
                        result.nextPc = ops.rsVal;
                else if (ctrl.jmp)
                        result.nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
                else if (taken)
                        result.nextPc = branchTarget;
                else
                        result.nextPc = pcPlus4;
        end

        assign result.aluResult = ctrl.lui ? {instr[15:0], 16'h0000} : aluOut;
        assign result.dAddr     = ops.rsVal + immSext; // Always signed offset
        assign result.storeData = ops.rtVal;
        assign result.dREN      = instrValid && ctrl.dREN;
        assign result.dWEN      = instrValid && ctrl.dWEN;

        // Write-back select
        always_comb begin
                wb.wen = instrValid && ctrl.regWrite;
                if (ctrl.jl) begin
                        wb.waddr = regIdx_t'(`LINK_REG);
                        wb.wdata = pcPlus4;
                end else begin
                        wb.waddr = ctrl.regDst ? rdIdx : rtIdx;
                        wb.wdata = ctrl.memToReg ? loadData : result.aluResult;
                end
        end

        // Decoder and write-back path must agree that JR only redirects
        always_comb begin
                jrNoWrite: assert final (!(ctrl.jmpReg && wb.wen))
                        else $error("JR requested a register write at pc %h", pc);
        end

endmodule

//--- execCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode and execute core, single cycle
// Fetch and data memory live outside
// loadData must be valid in the LW cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module execCore (
        input  logic                       clk,
        input  logic                       arstN,
        input  logic                       instrValid,
        input  cpu_types_pkg::word_t       pc,
        input  cpu_types_pkg::word_t       instr,
        input  cpu_types_pkg::word_t       loadData,
        output cpu_types_pkg::execResult_t result
);
        import cpu_types_pkg::*;

        ctrlWord_t ctrl;
        operands_t ops;
        wbReq_t    wb; // Loops back into the register file

        controlDecoder uDecoder (
                .instr (instr),
                .ctrl  (ctrl)
        );

        regFile uRegFile (
                .clk   (clk),
                .arstN (arstN),
                .rsIdx (instr[25:21]),
                .rtIdx (instr[20:16]),
                .wb    (wb),
                .ops   (ops)
        );

        aluUnit uAlu (
                .instrValid (instrValid),
                .pc         (pc),
                .instr      (instr),
                .loadData   (loadData),
                .ctrl       (ctrl),
                .ops        (ops),
                .result     (result),
                .wb         (wb)
        );

endmodule

//--- tb_execCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for execCore
// Register results are read back through SW storeData
// Outputs sampled on the falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "cpu_defines.svh"

module tb_execCore;
        import cpu_types_pkg::*;

        localparam int CLK_PERIOD  = 8;
        // Reset, idle and reset readback, rtype, imm, mem, branch, jump, wrap-up
        localparam int TEST_CYCLES = 3 + 34 + 4 * 24 + 19 + 6 + 10 + 7 + 1;

        logic        clk;
        logic        arstN;
        logic        instrValid;
        word_t       pc;
        word_t       instr;
        word_t       loadData;
        execResult_t result;

        word_t       model [`REG_COUNT]; // Expected register contents
        word_t       pcNow;
        word_t       lcgState = 32'hcac157ab;
        execResult_t got;
        int          wordErrs;
        int          pcErrs;
        int          strobeErrs;

        execCore dut (
                .clk        (clk),
                .arstN      (arstN),
                .instrValid (instrValid),
                .pc         (pc),
                .instr      (instr),
                .loadData   (loadData),
                .result     (result)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        function word_t nextRand();
                lcgState = lcgState * 32'd1664525 + 32'd1013904223;
                return lcgState;
        endfunction

        function automatic word_t sext(input logic [15:0] imm);
                return {{16{imm[15]}}, imm};
        endfunction

        function automatic word_t zext(input logic [15:0] imm);
                return {16'h0000, imm};
        endfunction

        function automatic word_t rType(input funct_t f, input regIdx_t rs, input regIdx_t rt,
                                        input regIdx_t rd, input logic [4:0] sh);
                return {6'b000000, rs, rt, rd, sh, f};
        endfunction

        function automatic word_t iType(input opcode_t op, input regIdx_t rs, input regIdx_t rt,
                                        input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        // Expected R-type result, straight from the MIPS definitions
        function automatic word_t refAlu(input funct_t f, input word_t a, input word_t b,
                                         input logic [4:0] sh);
                case (f)
                        ADD, ADDU: return a + b;
                        SUB, SUBU: return a - b;
                        AND:       return a & b;
                        OR:        return a | b;
                        XOR:       return a ^ b;
                        NOR:       return ~(a | b);
                        SLT:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        SLTU:      return (a < b) ? 32'd1 : 32'd0;
                        SLL:       return b << sh;
                        SRL:       return b >> sh;
                        default:   return '0;
                endcase
        endfunction

        task automatic checkWord(input string name, input word_t exp, input word_t act);
                if (act !== exp) begin
                        wordErrs++;
                        $display("ERR %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic checkPc(input string name, input word_t exp, input word_t act);
                if (act !== exp) begin
                        pcErrs++;
                        $display("ERR %s: expected nextPc %h, actual %h", name, exp, act);
                end
        endtask

        task automatic checkStrobe(input string name, input logic expRen, input logic expWen,
                                   input execResult_t act);
                if (act.dREN !== expRen || act.dWEN !== expWen) begin
                        strobeErrs++;
                        $display("ERR %s: expected ren/wen %b%b, actual %b%b", name,
                                 expRen, expWen, act.dREN, act.dWEN);
                end
        endtask

        function automatic void modelWrite(input regIdx_t idx, input word_t val);
                if (idx != '0)
                        model[idx] = val;
        endfunction

        // One valid instruction per cycle, write-back lands on the next edge
        task automatic issue(input word_t ins, input word_t ld);
                @(posedge clk);
                instrValid <= 1'b1;
                instr      <= ins;
                loadData   <= ld;
                pc         <= pcNow;
                @(negedge clk);
                got   = result;
                pcNow = pcNow + 32'd4;
        endtask

        task automatic readBack(input string name, input regIdx_t r);
                word_t at;
                at = pcNow;
                issue(iType(SW, 5'd0, r, 16'h0000), '0);
                checkWord(name, model[r], got.storeData);
                checkPc({name, " seq"}, at + 32'd4, got.nextPc);
        endtask

        task automatic loadReg(input regIdx_t r, input word_t value);
                issue(iType(LUI, 5'd0, r, value[31:16]), '0);
                modelWrite(r, {value[31:16], 16'h0000});
                issue(iType(ORI, r, r, value[15:0]), '0);
                modelWrite(r, value);
        endtask

        task automatic resetAndIdleTest();
                @(posedge clk);
                instrValid <= 1'b0; // Idle cycle with a store and a load on the bus
                instr      <= iType(SW, 5'd0, 5'd1, 16'h0004);
                @(negedge clk);
                checkStrobe("idle sw", 1'b0, 1'b0, result);
                @(posedge clk);
                instr    <= iType(LW, 5'd0, 5'd1, 16'h0004);
                loadData <= 32'hffff_ffff; // Must not reach r1 while idle
                @(negedge clk);
                checkStrobe("idle lw", 1'b0, 1'b0, result);
                for (int r = 0; r < `REG_COUNT; r++) begin
                        issue(iType(SW, 5'd0, regIdx_t'(r), 16'h0000), '0);
                        checkWord($sformatf("reset r%0d", r), '0, got.storeData);
                        checkStrobe("reset sw", 1'b0, 1'b1, got);
                end
        endtask

        task automatic rTypeTest();
                funct_t     opList [10] = '{ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL};
                logic [4:0] sh;
                for (int round = 0; round < 4; round++) begin
                        loadReg(5'd1, nextRand());
                        loadReg(5'd2, nextRand());
                        for (int i = 0; i < 10; i++) begin
                                sh = 5'(nextRand() >> 27);
                                issue(rType(opList[i], 5'd1, 5'd2, 5'd3, sh), '0);
                                modelWrite(5'd3, refAlu(opList[i], model[1], model[2], sh));
                                checkWord($sformatf("alu %s", opList[i].name()), model[3],
                                          got.aluResult);
                                readBack($sformatf("rtype %s", opList[i].name()), 5'd3);
                        end
                end
        endtask

        task automatic immTest();
                issue(iType(ADDI, 5'd0, 5'd4, 16'hfff0), '0);
                modelWrite(5'd4, sext(16'hfff0));
                readBack("addi neg", 5'd4);
                issue(iType(ADDI, 5'd4, 5'd5, 16'h0020), '0);
                modelWrite(5'd5, model[4] + sext(16'h0020));
                readBack("addi pos", 5'd5);
                issue(iType(SLTI, 5'd4, 5'd6, 16'h0001), '0);
                modelWrite(5'd6, ($signed(model[4]) < $signed(sext(16'h0001))) ? 32'd1 : 32'd0);
                readBack("slti true", 5'd6);
                issue(iType(SLTI, 5'd5, 5'd6, 16'hffff), '0);
                modelWrite(5'd6, ($signed(model[5]) < $signed(sext(16'hffff))) ? 32'd1 : 32'd0);
                readBack("slti false", 5'd6);
                issue(iType(ANDI, 5'd4, 5'd7, 16'h8f0f), '0);
                modelWrite(5'd7, model[4] & zext(16'h8f0f));
                readBack("andi", 5'd7);
                issue(iType(ORI, 5'd5, 5'd7, 16'h8000), '0);
                modelWrite(5'd7, model[5] | zext(16'h8000));
                readBack("ori", 5'd7);
                issue(iType(XORI, 5'd4, 5'd7, 16'hffff), '0);
                modelWrite(5'd7, model[4] ^ zext(16'hffff));
                readBack("xori", 5'd7);
                issue(iType(LUI, 5'd0, 5'd8, 16'hbeef), '0);
                modelWrite(5'd8, {16'hbeef, 16'h0000});
                readBack("lui", 5'd8);
                issue(iType(ADDI, 5'd0, 5'd0, 16'h1234), '0);
                issue(iType(LUI, 5'd0, 5'd0, 16'h5678), '0);
                readBack("r0 write", 5'd0);
        endtask

        task automatic memTest();
                word_t ld;
                ld = nextRand();
                loadReg(5'd9, 32'h1000_0100);
                issue(iType(LW, 5'd9, 5'd10, 16'hfffc), ld);
                checkStrobe("lw", 1'b1, 1'b0, got);
                checkWord("lw addr", model[9] + sext(16'hfffc), got.dAddr);
                modelWrite(5'd10, ld);
                readBack("lw data", 5'd10);
                issue(iType(SW, 5'd9, 5'd10, 16'h0008), '0);
                checkStrobe("sw", 1'b0, 1'b1, got);
                checkWord("sw addr", model[9] + sext(16'h0008), got.dAddr);
                checkWord("sw data", model[10], got.storeData);
                readBack("sw no write", 5'd10);
        endtask

        task automatic branchTest();
                word_t at;
                word_t v;
                v = nextRand();
                loadReg(5'd11, v);
                loadReg(5'd12, v);
                loadReg(5'd13, v + 32'd1);
                pcNow = 32'h0040_0100;
                at = pcNow;
                issue(iType(BEQ, 5'd11, 5'd12, 16'h0010), '0);
                checkPc("beq taken", at + 32'd4 + (sext(16'h0010) << 2), got.nextPc);
                at = pcNow;
                issue(iType(BEQ, 5'd11, 5'd13, 16'h0010), '0);
                checkPc("beq not taken", at + 32'd4, got.nextPc);
                at = pcNow;
                issue(iType(BNE, 5'd11, 5'd13, 16'hfff8), '0);
                checkPc("bne taken", at + 32'd4 + (sext(16'hfff8) << 2), got.nextPc);
                at = pcNow;
                issue(iType(BNE, 5'd11, 5'd12, 16'hfff8), '0);
                checkPc("bne not taken", at + 32'd4, got.nextPc);
        endtask

        task automatic jumpTest();
                word_t       at;
                word_t       linkPc;
                logic [25:0] tgt;
                tgt    = 26'h0abcdef;
                pcNow  = 32'h2fff_fffc; // pc + 4 lies in the next 256 MB region
                at     = pcNow;
                linkPc = at + 32'd4;
                issue({J, tgt}, '0);
                checkPc("j", {linkPc[31:28], tgt, 2'b00}, got.nextPc);
                at     = pcNow;
                linkPc = at + 32'd4;
                issue({JAL, tgt}, '0);
                checkPc("jal", {linkPc[31:28], tgt, 2'b00}, got.nextPc);
                modelWrite(regIdx_t'(`LINK_REG), linkPc);
                readBack("jal link", regIdx_t'(`LINK_REG));
                loadReg(5'd14, 32'h0040_2000);
                issue(rType(JR, 5'd14, 5'd0, 5'd15, 5'd0), '0);
                checkPc("jr", model[14], got.nextPc);
                readBack("jr no write", 5'd15);
        endtask

        initial begin
                clk        = 1'b0;
                arstN      = 1'b0;
                instrValid = 1'b0;
                pc         = '0;
                instr      = '0;
                loadData   = '0;
                pcNow      = 32'h0040_0000;
                wordErrs   = 0;
                pcErrs     = 0;
                strobeErrs = 0;
                for (int r = 0; r < `REG_COUNT; r++)
                        model[r] = '0;
                repeat (3) @(posedge clk);
                arstN <= 1'b1;
                resetAndIdleTest();
                rTypeTest();
                immTest();
                memTest();
                branchTest();
                jumpTest();
                @(posedge clk);
                instrValid <= 1'b0;
                @(negedge clk);
                $display("Errors: word %0d, pc %0d, strobe %0d", wordErrs, pcErrs, strobeErrs);
                if (wordErrs + pcErrs + strobeErrs == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

        // Watchdog
        initial begin
                #(TEST_CYCLES * CLK_PERIOD * 2);
                $display("Timeout: the tests did not finish in time");
                $display("Something failed");
                $finish;
        end

endmodule

//--- filelist.f
+incdir+.
cpu_types_pkg.sv
controlDecoder.sv
regFile.sv
aluUnit.sv
execCore.sv
tb_execCore.sv

//--- Bender.yml
package:
  name: exec_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_types_pkg.sv
      - controlDecoder.sv
      - regFile.sv
      - aluUnit.sv
      - execCore.sv
  - target: test
    files:
      - tb_execCore.sv
